// File: verif/router_input.txt
# test in_port dest_x dest_y payload(hex) out_port
# ports: 0 core, 1 north, 2 east, 3 south, 4 west; router at x 1, y 1
2 0 1 1 a001 0
2 0 3 1 a002 2
2 1 1 3 a003 3
2 1 1 0 a004 1
2 2 0 2 a005 4
2 2 2 0 a006 2
2 3 1 1 a007 0
2 3 1 3 a008 3
2 4 0 3 a009 4
2 4 1 0 a00a 1
3 0 3 0 b001 2
3 0 2 3 b002 2
3 0 1 0 b003 1
3 3 0 0 b004 4
3 3 0 1 b005 4
3 2 1 1 b006 0
4 0 2 1 c001 2
4 0 3 0 c002 2
4 0 2 2 c003 2
4 0 3 3 c004 2
4 0 2 0 c005 2
4 0 3 1 c006 2
5 1 1 1 d001 0
5 2 1 1 d002 0
5 3 1 1 d003 0
5 4 1 1 d004 0
5 1 1 1 d005 0
5 2 1 1 d006 0
5 3 1 1 d007 0
5 4 1 1 d008 0

// File: tb.f
hdl/noc_pkg.sv
hdl/noc_input_fifo.sv
hdl/noc_route_calc.sv
hdl/noc_switch.sv
hdl/noc_router.sv
verif/noc_router_tb.sv

// File: Makefile
# Verilator build and run of the mesh router testbench
VERILATOR := verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := noc_router_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "make test   build, run and check the log"
	@echo "make clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/noc_router_tb.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// Testbench for the mesh router
//   Packet list read from the input file
//   Port drivers and output scoreboard
//   Reset, routing, ordering, flow control
//   and round-robin fairness tests
// ----------------------------------------

module noc_router_tb;

  localparam int N      = noc_pkg::N_PORTS;
  localparam int DEPTH  = 4;
  localparam int X_HERE = 1;
  localparam int Y_HERE = 1;
  localparam int LIMIT  = 1000;               // Cycle timeout of every wait

  logic                     clk = 1'b0;
  logic                     reset_n;
  noc_pkg::packet_t [N-1:0] i_data;
  noc_pkg::packet_t [N-1:0] o_data;
  noc_pkg::port_vec_t       i_data_val;
  noc_pkg::port_vec_t       o_en;
  noc_pkg::port_vec_t       o_data_val;
  noc_pkg::port_vec_t       i_en;
  noc_pkg::port_vec_t       en_force;         // i_en when not random
  bit                       en_random;
  int l_test[$], l_in[$], l_x[$], l_y[$], l_pay[$], l_out[$];  // One entry per file line
  int line_of[int];                           // Payload to line index
  int exp_q[N][$];                            // Lines pending per output
  int pend[N][$];                             // Lines still to send per input
  int core_src[$];                            // Input of each core delivery
  int errors    = 0;
  int test_errs = 0;
  int n_pass    = 0;
  int n_fail    = 0;
  int sent;

  noc_router #(
    .X_LOC      (X_HERE),
    .Y_LOC      (Y_HERE),
    .X_NODES    (4),
    .Y_NODES    (4),
    .FIFO_DEPTH (DEPTH)
  ) dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  always #4 clk = ~clk;                       // 8 ns period

  // Expected output port by the XY and core delivery rules
  function automatic int xy_port(input int x, input int y);
    if (x == X_HERE && y == Y_HERE) return noc_pkg::PORT_CORE;
    if (x > X_HERE) return noc_pkg::PORT_EAST;
    if (x < X_HERE) return noc_pkg::PORT_WEST;
    return (y > Y_HERE) ? noc_pkg::PORT_SOUTH : noc_pkg::PORT_NORTH;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int q = 0; q < N; q++) begin
      n += exp_q[q].size();
    end
    return n;
  endfunction

  task automatic load_file();
    int    fd, t, ip, x, y, pl, op;
    string line;
    fd = $fopen("verif/router_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the packet file verif/router_input.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.getc(0) == "#") continue;      // Column notes
      if ($sscanf(line, "%d %d %d %d %h %d", t, ip, x, y, pl, op) != 6) continue;
      if (op != xy_port(x, y)) begin
        $display("FAILED %0t file port of payload %h expected %0d got %0d",
                 $time, pl, xy_port(x, y), op);
        errors++;
      end
      line_of[pl] = l_test.size();
      l_test.push_back(t);
      l_in.push_back(ip);
      l_x.push_back(x);
      l_y.push_back(y);
      l_pay.push_back(pl);
      l_out.push_back(op);
    end
    $fclose(fd);
    if (l_test.size() == 0) begin
      $display("No packets found in the packet file");
      errors++;
    end
  endtask

  // Falling edge, new downstream enables
  task automatic tick();
    @(negedge clk);
    i_en = en_random ? noc_pkg::port_vec_t'($urandom) : en_force;
  endtask

  // Send every packet of one test, each input in file order
  task automatic send_test(input int t);
    int k;
    int cycles;
    bit busy;
    for (int i = 0; i < l_test.size(); i++) begin
      if (l_test[i] == t) pend[l_in[i]].push_back(i);
    end
    busy = 1'b1;
    for (cycles = 0; busy && cycles < LIMIT; cycles++) begin
      tick();
      busy = 1'b0;
      for (int p = 0; p < N; p++) begin
        i_data_val[p] = 1'b0;
        if (pend[p].size() > 0 && o_en[p]) begin  // Only while the queue has room
          k = pend[p].pop_front();
          i_data[p].coord.x_dest  = 2'(l_x[k]);
          i_data[p].coord.y_dest  = 2'(l_y[k]);
          i_data[p].coord.payload = 16'(l_pay[k]);
          i_data_val[p] = 1'b1;
          exp_q[l_out[k]].push_back(k);
          sent++;
        end
        busy |= (pend[p].size() > 0);
      end
    end
    tick();
    i_data_val = '0;
    if (busy) begin
      $display("Timeout while sending the packets of test %0d", t);
      errors++;
      for (int p = 0; p < N; p++) pend[p].delete();
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (pending() > 0 && cycles < LIMIT) begin
      tick();
      cycles++;
    end
    for (int q = 0; q < N; q++) begin
      for (int i = 0; i < exp_q[q].size(); i++) begin
        $display("Packet %h never left on output %0d", l_pay[exp_q[q][i]], q);
        errors++;
      end
      exp_q[q].delete();
    end
  endtask

  // ----------------------------------------
  // Scoreboard for one delivered packet
  task automatic check_out(input int q, input noc_pkg::packet_t pk);
    int k;
    int pos;
    if (!i_en[q]) begin                       // Valid only while downstream takes it
      $display("FAILED %0t o_data_val[%0d] expected 0 got 1", $time, q);
      errors++;
    end
    if (!line_of.exists(int'(pk.coord.payload))) begin
      $display("Unknown payload %h came out on output %0d", pk.coord.payload, q);
      errors++;
      return;
    end
    k = line_of[int'(pk.coord.payload)];
    if (l_out[k] != q) begin
      $display("FAILED %0t output port of payload %h expected %0d got %0d",
               $time, pk.coord.payload, l_out[k], q);
      errors++;
    end
    if (int'(pk.flat.node_dest) != l_y[k] * 4 + l_x[k]) begin  // Y above X
      $display("FAILED %0t o_data[%0d].node_dest expected %0d got %0d",
               $time, q, l_y[k] * 4 + l_x[k], pk.flat.node_dest);
      errors++;
    end
    pos = -1;
    for (int i = 0; i < exp_q[q].size() && pos < 0; i++) begin
      if (exp_q[q][i] == k) pos = i;
    end
    if (pos < 0) begin
      $display("Payload %h on output %0d was not waiting there", pk.coord.payload, q);
      errors++;
      return;
    end
    for (int i = 0; i < pos; i++) begin
      if (l_in[exp_q[q][i]] == l_in[k]) begin  // Older packet from the same input
        $display("FAILED %0t o_data[%0d].payload expected %h got %h",
                 $time, q, l_pay[exp_q[q][i]], pk.coord.payload);
        errors++;
        break;
      end
    end
    exp_q[q].delete(pos);
    if (q == noc_pkg::PORT_CORE) core_src.push_back(l_in[k]);
  endtask

  always @(posedge clk) begin
    if (reset_n) begin
      for (int q = 0; q < N; q++) begin
        if (o_data_val[q]) check_out(q, o_data[q]);  // Transfer happens at this edge
      end
    end
  end

  task automatic finish_test(input int num, input string name);
    if (errors == test_errs) begin
      n_pass++;
      $display("Test %0d %s: ok", num, name);
    end else begin
      n_fail++;
      $display("Test %0d %s: failed with %0d errors", num, name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  // ----------------------------------------
  initial begin
    int mask;
    void'($urandom(32'he2d3));
    reset_n      = 1'b0;
    i_data       = '0;
    i_data_val   = '0;
    i_en         = '1;
    en_force     = '1;
    en_random    = 1'b0;
    sent         = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    tick();
    if (o_en !== '1) begin
      $display("FAILED %0t o_en expected %b got %b", $time, 5'b11111, o_en);
      errors++;
    end
    if (o_data_val !== '0) begin
      $display("FAILED %0t o_data_val expected %b got %b", $time, 5'b00000, o_data_val);
      errors++;
    end
    finish_test(1, "reset state");

    load_file();
    send_test(2);
    wait_drain();
    finish_test(2, "XY routing");

    en_random = 1'b1;                         // Random back-pressure on all outputs
    send_test(3);
    wait_drain();
    en_random = 1'b0;
    finish_test(3, "ordering under back-pressure");

    en_force     = ~noc_pkg::port_vec_t'(1 << noc_pkg::PORT_EAST);
    tick();
    sent = 0;
    fork
      send_test(4);
      begin
        int cycles;
        cycles = 0;
        while (o_en[noc_pkg::PORT_CORE] && cycles < LIMIT) begin
          @(negedge clk);
          cycles++;
        end
        if (o_en[noc_pkg::PORT_CORE]) begin
          $display("Core input enable never dropped while east was blocked");
          errors++;
        end else if (sent != DEPTH) begin
          $display("FAILED %0t packets held expected %0d got %0d", $time, DEPTH, sent);
          errors++;
        end
        repeat (8) @(negedge clk);            // Hold the block, east stays quiet
        en_force     = '1;
        i_en         = '1;
      end
    join
    wait_drain();
    finish_test(4, "east back-pressure");

    core_src.delete();
    send_test(5);
    wait_drain();
    for (int i = 0; i + 4 <= core_src.size(); i++) begin
      mask = 0;
      for (int j = i; j < i + 4; j++) mask |= 1 << core_src[j];
      if (mask != 'b11110) begin              // North, east, south, west once each
        $display("FAILED %0t core sources from delivery %0d expected %b got %b",
                 $time, i, 5'b11110, 5'(mask));
        errors++;
      end
    end
    finish_test(5, "round-robin fairness");

    $display("Tests passed %0d, failed %0d", n_pass, n_fail);
    if (errors == 0 && n_fail == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/noc_router.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// Input buffered mesh router, top level
//   Five input queues
//   Five XY route calculators
//   Round-robin switch
// ----------------------------------------

module noc_router #(
  parameter int X_LOC      = 1,               // This router's column
  parameter int Y_LOC      = 1,               // This router's row
  parameter int X_NODES    = 4,               // Mesh width, 4 at most
  parameter int Y_NODES    = 4,               // Mesh height, 4 at most
  parameter int FIFO_DEPTH = 4                // Input queue entries
) (
  input  wire logic                                      clk,
  input  wire logic                                      reset_n,

  // Upstream side
  // ----------------------------------------
  input  wire noc_pkg::packet_t   [noc_pkg::N_PORTS-1:0] i_data,     // Core, N, E, S, W
  input  wire noc_pkg::port_vec_t                        i_data_val,
  output wire noc_pkg::port_vec_t                        o_en,       // Queue has space

  // Downstream side
  // ----------------------------------------
  output wire noc_pkg::packet_t   [noc_pkg::N_PORTS-1:0] o_data,     // Core, N, E, S, W
  output wire noc_pkg::port_vec_t                        o_data_val,
  input  wire noc_pkg::port_vec_t                        i_en        // Downstream can take one
);

  wire noc_pkg::packet_t   [noc_pkg::N_PORTS-1:0] head_data;  // Queue heads
  wire noc_pkg::port_vec_t                        head_val;   // Queue not empty
  wire noc_pkg::port_vec_t [noc_pkg::N_PORTS-1:0] req;        // Per input, bit per output
  wire noc_pkg::port_vec_t                        pop;        // Switch took the head

  // Input queues
  for (genvar p = 0; p < noc_pkg::N_PORTS; p++) begin : g_fifo
    noc_input_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .i_pop      (pop[p]),
      .o_data     (head_data[p]),
      .o_data_val (head_val[p]),
      .o_en       (o_en[p])
    );
  end

  // Route decision on each queue head
  for (genvar p = 0; p < noc_pkg::N_PORTS; p++) begin : g_route
    noc_route_calc #(
      .X_LOC   (X_LOC),
      .Y_LOC   (Y_LOC),
      .X_NODES (X_NODES),
      .Y_NODES (Y_NODES)
    ) u_route (
      .i_data     (head_data[p]),
      .i_data_val (head_val[p]),
      .o_req      (req[p])
    );
  end

  noc_switch u_switch (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_req      (req),
    .i_data     (head_data),
    .i_en       (i_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .o_pop      (pop)
  );

endmodule

`default_nettype wire

// File: hdl/noc_switch.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// Switch for the five router ports
//   Round-robin arbiter per output
//   Packet crossbar and output valids
//   Pop back to each winning input queue
// ----------------------------------------

module noc_switch (
  input  wire logic                                      clk,
  input  wire logic                                      reset_n,
  input  wire noc_pkg::port_vec_t [noc_pkg::N_PORTS-1:0] i_req,  // Per input, bit per output
  input  wire noc_pkg::packet_t   [noc_pkg::N_PORTS-1:0] i_data, // Queue heads
  input  wire noc_pkg::port_vec_t                        i_en,   // Downstream enables
  output noc_pkg::packet_t        [noc_pkg::N_PORTS-1:0] o_data,
  output noc_pkg::port_vec_t                             o_data_val,
  output noc_pkg::port_vec_t                             o_pop
);

  localparam int N     = noc_pkg::N_PORTS;
  localparam int PTR_W = $clog2(noc_pkg::N_PORTS);

  noc_pkg::port_vec_t [N-1:0] out_req;         // Per output, bit per input
  noc_pkg::port_vec_t [N-1:0] grant;           // Per output, bit per input
  logic [N-1:0][PTR_W-1:0]    sel;             // Winning input per output
  logic [N-1:0][PTR_W-1:0]    rr_ptr;          // Highest priority input per output

  // Request transpose
  // ----------------------------------------
  always_comb begin
    for (int q = 0; q < N; q++) begin
      for (int p = 0; p < N; p++) begin
        out_req[q][p] = i_req[p][q];
      end
    end
  end

  // Arbitration
  // ----------------------------------------
  always_comb begin
    int idx;
    grant = '0;
    sel   = '0;
    for (int q = 0; q < N; q++) begin
      // Scan from the far end so the input nearest the pointer wins
      for (int k = N - 1; k >= 0; k--) begin
        idx = int'(rr_ptr[q]) + k;
        if (idx >= N) begin
          idx = idx - N;
        end
        if (out_req[q][idx]) begin
          sel[q] = PTR_W'(idx);
        end
      end
      if (i_en[q] && (out_req[q] != '0)) begin
        grant[q][sel[q]] = 1'b1;               // Nobody wins while blocked
      end
    end
  end

  // Crossbar, valids and pops
  // ----------------------------------------
  always_comb begin
    o_pop = '0;
    for (int q = 0; q < N; q++) begin
      o_data[q]     = i_data[sel[q]];
      o_data_val[q] = |grant[q];
      o_pop         = o_pop | grant[q];        // One request per input, so one grant at most
    end
  end

  // Pointer moves to one past the winner
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rr_ptr <= '0;
    end else begin
      for (int q = 0; q < N; q++) begin
        if (o_data_val[q]) begin
          rr_ptr[q] <= (sel[q] == PTR_W'(N - 1)) ? '0 : sel[q] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/noc_route_calc.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// XY route decision for one queue head
//   Own node in flat view goes to core
//   Else X first, then Y, one-hot request
// ----------------------------------------

module noc_route_calc #(
  parameter int X_LOC   = 0,                   // This router's column
  parameter int Y_LOC   = 0,                   // This router's row
  parameter int X_NODES = 4,
  parameter int Y_NODES = 4
) (
  input  wire noc_pkg::packet_t i_data,        // Head of the input queue
  input  wire logic             i_data_val,
  output noc_pkg::port_vec_t    o_req          // One-hot output request
);

  localparam int X_LAST_I = X_NODES - 1;
  localparam int Y_LAST_I = Y_NODES - 1;

  localparam logic [noc_pkg::COORD_W-1:0] X_HERE = X_LOC[noc_pkg::COORD_W-1:0];
  localparam logic [noc_pkg::COORD_W-1:0] Y_HERE = Y_LOC[noc_pkg::COORD_W-1:0];
  localparam logic [noc_pkg::COORD_W-1:0] X_LAST = X_LAST_I[noc_pkg::COORD_W-1:0];
  localparam logic [noc_pkg::COORD_W-1:0] Y_LAST = Y_LAST_I[noc_pkg::COORD_W-1:0];
  localparam logic [noc_pkg::NODE_W-1:0]  NODE_HERE = {Y_HERE, X_HERE};

  logic [noc_pkg::COORD_W-1:0] x_dest;         // Folded into the mesh
  logic [noc_pkg::COORD_W-1:0] y_dest;

  always_comb begin
    // Coordinates past the mesh edge fold onto the last row or column
    x_dest = (i_data.coord.x_dest > X_LAST) ? X_LAST : i_data.coord.x_dest;
    y_dest = (i_data.coord.y_dest > Y_LAST) ? Y_LAST : i_data.coord.y_dest;
    o_req  = '0;
    if (i_data_val) begin
      if (i_data.flat.node_dest == NODE_HERE) begin
        o_req[noc_pkg::PORT_CORE] = 1'b1;      // Arrived
      end else if (x_dest > X_HERE) begin
        o_req[noc_pkg::PORT_EAST] = 1'b1;
      end else if (x_dest < X_HERE) begin
        o_req[noc_pkg::PORT_WEST] = 1'b1;
      end else if (y_dest > Y_HERE) begin
        o_req[noc_pkg::PORT_SOUTH] = 1'b1;
      end else if (y_dest < Y_HERE) begin
        o_req[noc_pkg::PORT_NORTH] = 1'b1;
      end else begin
        o_req[noc_pkg::PORT_CORE] = 1'b1;      // Folded destination ends here
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/noc_input_fifo.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// Input queue for one router port
//   Circular buffer with occupancy count
//   Registered head packet and valid
//   Enable to upstream while not full
// ----------------------------------------

module noc_input_fifo #(
  parameter int FIFO_DEPTH = 4                 // Power of two, 2 or more
) (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  wire noc_pkg::packet_t i_data,        // From upstream
  input  wire logic             i_data_val,
  input  wire logic             i_pop,         // From switch, head taken this cycle
  output noc_pkg::packet_t      o_data,        // Head packet
  output logic                  o_data_val,    // Queue not empty
  output logic                  o_en           // Space for one more packet
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;            // Holds 0 to FIFO_DEPTH

  noc_pkg::packet_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_next;                   // Head slot after this edge
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             pop;
  logic             head_bypass;               // New packet becomes the head directly

  assign o_en    = (count != CNT_W'(FIFO_DEPTH));
  assign push    = i_data_val & o_en;
  assign pop     = i_pop & o_data_val;         // Ignore pops on an empty queue
  assign rd_next = pop ? rd_ptr + 1'b1 : rd_ptr;

  // Queue is empty once the pop is applied, so the write lands at the head
  assign head_bypass = push & ((count == '0) | (pop & (count == CNT_W'(1))));

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  // Storage and head stage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
    o_data <= head_bypass ? i_data : mem[rd_next];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_data_val <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;               // Wraps at FIFO_DEPTH
      end
      rd_ptr     <= rd_next;
      count      <= count_next;
      o_data_val <= (count_next != '0);
    end
  end

endmodule

`default_nettype wire

// File: hdl/noc_pkg.sv
`default_nettype none
// ----------------------------------------
// Shared definitions for the mesh router
//   Coordinate and payload widths
//   Port index names and port bit vector
//   Packet word with coord and flat views
// ----------------------------------------

package noc_pkg;

  localparam int COORD_W   = 2;           // One mesh coordinate, up to 4 nodes
  localparam int NODE_W    = 2 * COORD_W; // Flat node number, Y above X
  localparam int PAYLOAD_W = 16;
  localparam int N_PORTS   = 5;

  // Port indices, same order on inputs and outputs
  localparam int PORT_CORE  = 0;
  localparam int PORT_NORTH = 1;          // Towards smaller Y
  localparam int PORT_EAST  = 2;          // Towards larger X
  localparam int PORT_SOUTH = 3;          // Towards larger Y
  localparam int PORT_WEST  = 4;          // Towards smaller X

  typedef logic [N_PORTS-1:0] port_vec_t; // One bit per port

  typedef struct packed {
    logic [COORD_W-1:0]   y_dest;
    logic [COORD_W-1:0]   x_dest;
    logic [PAYLOAD_W-1:0] payload;
  } coord_view_t;

  typedef struct packed {
    logic [NODE_W-1:0]    node_dest;      // Same bits as {y_dest, x_dest}
    logic [PAYLOAD_W-1:0] payload;
  } flat_view_t;

  typedef union packed {
    coord_view_t coord;                   // Direction choice
    flat_view_t  flat;                    // Local delivery check
  } packet_t;

endpackage

`default_nettype wire
